//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_id_stage
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert --timing --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/id_pkg.sv
design/decode_if.sv
design/id_latch.sv
design/inst_decoder.sv
design/reg_file.sv
design/branch_unit.sv
design/id_stage.sv
dv/tb_id_stage.sv

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit #(
    parameter int unsigned XLEN = id_pkg::xlen
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            out_valid,
    input  logic [XLEN-1:0] pc,
    decode_if.branch        bif,
    output logic            br_taken,
    output logic [XLEN-1:0] br_target,
    output logic [XLEN-1:0] alu_src1,
    output logic [XLEN-1:0] alu_src2,
    output logic [XLEN-1:0] rkd_value
);
    import id_pkg::*;

    logic [XLEN-1:0] rj_value;
    logic            rj_eq_rd;
    logic            rj_lt_rd;
    logic            rj_ltu_rd;

    assign rj_value  = bif.rdata1;
    assign rkd_value = bif.rdata2;   // rk, or rd for branches

    assign rj_eq_rd  = rj_value == rkd_value;
    assign rj_lt_rd  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu_rd = rj_value < rkd_value;

    always_comb begin
        case (bif.br_cond)
            br_eq:     br_taken = rj_eq_rd;
            br_ne:     br_taken = !rj_eq_rd;
            br_lt:     br_taken = rj_lt_rd;
            br_ge:     br_taken = !rj_lt_rd;
            br_ltu:    br_taken = rj_ltu_rd;
            br_geu:    br_taken = !rj_ltu_rd;
            br_always: br_taken = 1'b1;
            default:   br_taken = 1'b0;  // never, also for an empty stage
        endcase
    end

    // jirl jumps off rj, everything else is pc relative
    assign br_target = (bif.kind == kind_jirl) ? rj_value + bif.br_offs : pc + bif.br_offs;

    assign alu_src1 = bif.src1_is_pc  ? pc      : rj_value;
    assign alu_src2 = bif.src2_is_imm ? bif.imm : rkd_value;  // imm is 4 for bl and jirl

    // a redirect must come from a live instruction
    a_taken_valid: assert property (@(posedge clk) disable iff (!resetn)
        br_taken |-> out_valid);

endmodule

//--- design/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
    import id_pkg::*;

    inst_kind_e             kind;
    alu_op_e                alu_op;
    br_cond_e               br_cond;
    logic [xlen-1:0]        imm;
    logic [xlen-1:0]        br_offs;     // pc-relative or rj-relative offset, already shifted
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic [reg_addr_w-1:0]  raddr1;
    logic [reg_addr_w-1:0]  raddr2;
    logic [xlen-1:0]        rdata1;
    logic [xlen-1:0]        rdata2;
    logic                   rf_we;
    logic [reg_addr_w-1:0]  rf_waddr;

    modport decoder (output kind, alu_op, br_cond, imm, br_offs, src1_is_pc, src2_is_imm,
                     output raddr1, raddr2, rf_we, rf_waddr);
    modport regfile (input raddr1, raddr2, output rdata1, rdata2);
    modport branch  (input kind, alu_op, br_cond, imm, br_offs, src1_is_pc, src2_is_imm,
                     input rdata1, rdata2, rf_we, rf_waddr);

endinterface

//--- design/id_latch.sv
`timescale 1ns/1ps

module id_latch #(
    parameter int unsigned XLEN = id_pkg::xlen
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_valid,
    input  logic [XLEN-1:0] in_inst,
    input  logic [XLEN-1:0] in_pc,
    input  logic            ex_allowin,
    input  logic            br_taken,
    output logic            id_allowin,
    output logic            out_valid,
    output logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] pc
);
    logic valid_q;
    logic accept;

    // no stall source left, so the stage only waits on execute
    assign id_allowin = ~valid_q | ex_allowin;
    assign out_valid  = valid_q;

    // fetch input behind a taken branch is the wrong path
    assign accept = in_valid & id_allowin & ~br_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (id_allowin) begin
            valid_q <= accept;  // empties on squash or when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst <= in_inst;
            pc   <= in_pc;
        end
    end

    // held instruction must not move under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !ex_allowin |=> out_valid && $stable(inst) && $stable(pc));

endmodule

//--- design/id_pkg.sv
package id_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 32;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd1; // bl writes the return pc here

    // instruction field positions (lsb of each field)
    localparam int unsigned op6_lsb = 26;
    localparam int unsigned op4_lsb = 22;
    localparam int unsigned op2_lsb = 20;
    localparam int unsigned op5_lsb = 15;
    localparam int unsigned rd_lsb  = 0;
    localparam int unsigned rj_lsb  = 5;
    localparam int unsigned rk_lsb  = 10;
    localparam int unsigned i12_lsb = 10;
    localparam int unsigned i16_lsb = 10;
    localparam int unsigned i20_lsb = 5;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_nor, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui,
        alu_none                          // plain b, nothing to compute
    } alu_op_e;

    typedef enum logic [3:0] {
        kind_alu_rr, kind_alu_imm, kind_lui, kind_pcadd,
        kind_cond_branch, kind_b, kind_bl, kind_jirl,
        kind_illegal
    } inst_kind_e;

    typedef enum logic [2:0] {
        br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_always, br_never
    } br_cond_e;

    typedef enum logic [2:0] {
        imm_si12, imm_ui12, imm_ui5, imm_si20_hi, imm_four
    } imm_kind_e;

endpackage

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
    parameter int unsigned XLEN     = id_pkg::xlen,
    parameter int unsigned NUM_REGS = id_pkg::num_regs
) (
    input  logic                          clk,
    input  logic                          resetn,
    // from fetch
    input  logic                          in_valid,
    input  logic [XLEN-1:0]               in_inst,
    input  logic [XLEN-1:0]               in_pc,
    output logic                          id_allowin,
    // to execute
    input  logic                          ex_allowin,
    output logic                          out_valid,
    output id_pkg::alu_op_e               alu_op,
    output logic [XLEN-1:0]               alu_src1,
    output logic [XLEN-1:0]               alu_src2,
    output logic [XLEN-1:0]               rkd_value,
    output logic                          rf_we,
    output logic [id_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [XLEN-1:0]               pc,
    // redirect back to fetch
    output logic                          br_taken,
    output logic [XLEN-1:0]               br_target,
    // writeback port
    input  logic                          wb_we,
    input  logic [id_pkg::reg_addr_w-1:0] wb_waddr,
    input  logic [XLEN-1:0]               wb_wdata
);
    logic [XLEN-1:0] inst;

    decode_if u_dec_if ();

    id_latch #(.XLEN(XLEN)) u_id_latch (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .ex_allowin (ex_allowin),
        .br_taken   (br_taken),
        .id_allowin (id_allowin),
        .out_valid  (out_valid),
        .inst       (inst),
        .pc         (pc)
    );

    inst_decoder u_inst_decoder (
        .inst      (inst),
        .out_valid (out_valid),
        .dif       (u_dec_if.decoder)
    );

    reg_file #(.XLEN(XLEN), .NUM_REGS(NUM_REGS)) u_reg_file (
        .clk      (clk),
        .resetn   (resetn),
        .wb_we    (wb_we),
        .wb_waddr (wb_waddr),
        .wb_wdata (wb_wdata),
        .rf       (u_dec_if.regfile)
    );

    branch_unit #(.XLEN(XLEN)) u_branch_unit (
        .clk       (clk),
        .resetn    (resetn),
        .out_valid (out_valid),
        .pc        (pc),
        .bif       (u_dec_if.branch),
        .br_taken  (br_taken),
        .br_target (br_target),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .rkd_value (rkd_value)
    );

    // decoded control goes straight on to execute
    assign alu_op   = u_dec_if.alu_op;
    assign rf_we    = u_dec_if.rf_we;
    assign rf_waddr = u_dec_if.rf_waddr;

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [id_pkg::xlen-1:0] inst,
    input  logic                    out_valid,
    decode_if.decoder               dif
);
    import id_pkg::*;

    logic [5:0]            op6;
    logic [3:0]            op4;
    logic [1:0]            op2;
    logic [4:0]            op5;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [11:0]           i12;
    logic [15:0]           i16;
    logic [19:0]           i20;
    logic [25:0]           i26;
    imm_kind_e             ikind;
    br_cond_e              cond;

    assign op6 = inst[op6_lsb +: 6];
    assign op4 = inst[op4_lsb +: 4];
    assign op2 = inst[op2_lsb +: 2];
    assign op5 = inst[op5_lsb +: 5];
    assign rd  = inst[rd_lsb +: reg_addr_w];
    assign rj  = inst[rj_lsb +: reg_addr_w];
    assign rk  = inst[rk_lsb +: reg_addr_w];
    assign i12 = inst[i12_lsb +: 12];
    assign i16 = inst[i16_lsb +: 16];
    assign i20 = inst[i20_lsb +: 20];
    assign i26 = {inst[rd_lsb +: 10], i16};  // offs[25:16] sits in the low bits

    always_comb begin
        dif.kind   = kind_illegal;
        dif.alu_op = alu_none;
        cond       = br_never;
        ikind      = imm_four;
        case (op6)
            6'h00: begin
                if (op4 == 4'h0 && op2 == 2'h1) begin
                    dif.kind = kind_alu_rr;
                    case (op5)
                        5'h00: dif.alu_op = alu_add;
                        5'h02: dif.alu_op = alu_sub;
                        5'h04: dif.alu_op = alu_slt;
                        5'h05: dif.alu_op = alu_sltu;
                        5'h08: dif.alu_op = alu_nor;
                        5'h09: dif.alu_op = alu_and;
                        5'h0a: dif.alu_op = alu_or;
                        5'h0b: dif.alu_op = alu_xor;
                        5'h0e: dif.alu_op = alu_sll;
                        5'h0f: dif.alu_op = alu_srl;
                        5'h10: dif.alu_op = alu_sra;
                        default: dif.kind = kind_illegal;
                    endcase
                end else if (op4 == 4'h1 && op2 == 2'h0) begin
                    dif.kind = kind_alu_imm;
                    ikind    = imm_ui5;
                    case (op5)
                        5'h01: dif.alu_op = alu_sll;
                        5'h09: dif.alu_op = alu_srl;
                        5'h11: dif.alu_op = alu_sra;
                        default: dif.kind = kind_illegal;
                    endcase
                end else begin
                    dif.kind = kind_alu_imm;
                    ikind    = imm_si12;
                    case (op4)
                        4'h8: dif.alu_op = alu_slt;
                        4'h9: dif.alu_op = alu_sltu;
                        4'ha: dif.alu_op = alu_add;
                        4'hd: begin dif.alu_op = alu_and; ikind = imm_ui12; end
                        4'he: begin dif.alu_op = alu_or;  ikind = imm_ui12; end
                        4'hf: begin dif.alu_op = alu_xor; ikind = imm_ui12; end
                        default: dif.kind = kind_illegal;
                    endcase
                end
            end
            6'h05: if (!inst[25]) begin
                dif.kind = kind_lui;   dif.alu_op = alu_lui; ikind = imm_si20_hi;
            end
            6'h07: if (!inst[25]) begin
                dif.kind = kind_pcadd; dif.alu_op = alu_add; ikind = imm_si20_hi;
            end
            6'h13: begin dif.kind = kind_jirl; dif.alu_op = alu_add; cond = br_always; end
            6'h14: begin dif.kind = kind_b;    cond = br_always; end
            6'h15: begin dif.kind = kind_bl;   dif.alu_op = alu_add; cond = br_always; end
            6'h16: begin dif.kind = kind_cond_branch; cond = br_eq;  end
            6'h17: begin dif.kind = kind_cond_branch; cond = br_ne;  end
            6'h18: begin dif.kind = kind_cond_branch; cond = br_lt;  end
            6'h19: begin dif.kind = kind_cond_branch; cond = br_ge;  end
            6'h1a: begin dif.kind = kind_cond_branch; cond = br_ltu; end
            6'h1b: begin dif.kind = kind_cond_branch; cond = br_geu; end
            default: ;
        endcase
    end

    // an empty stage never redirects fetch
    assign dif.br_cond = out_valid ? cond : br_never;

    always_comb begin
        case (ikind)
            imm_si12:    dif.imm = {{(xlen-12){i12[11]}}, i12};
            imm_ui12:    dif.imm = {{(xlen-12){1'b0}}, i12};
            imm_ui5:     dif.imm = {{(xlen-5){1'b0}}, i12[4:0]};  // shift amount
            imm_si20_hi: dif.imm = {i20, 12'b0};
            default:     dif.imm = xlen'(4);                      // link value pc+4
        endcase
    end

    assign dif.br_offs = (dif.kind == kind_b || dif.kind == kind_bl)
                       ? {{(xlen-28){i26[25]}}, i26, 2'b0}
                       : {{(xlen-18){i16[15]}}, i16, 2'b0};

    assign dif.src1_is_pc  = dif.kind inside {kind_pcadd, kind_bl, kind_jirl};
    assign dif.src2_is_imm = dif.kind inside {kind_alu_imm, kind_lui, kind_pcadd,
                                              kind_bl, kind_jirl};

    assign dif.raddr1   = rj;
    assign dif.raddr2   = (dif.kind == kind_cond_branch) ? rd : rk;  // branches compare rj, rd
    assign dif.rf_waddr = (dif.kind == kind_bl) ? link_reg : rd;
    assign dif.rf_we    = out_valid
                        & !(dif.kind inside {kind_cond_branch, kind_b, kind_illegal});

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int unsigned XLEN     = id_pkg::xlen,
    parameter int unsigned NUM_REGS = id_pkg::num_regs
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          wb_we,
    input  logic [id_pkg::reg_addr_w-1:0] wb_waddr,
    input  logic [XLEN-1:0]               wb_wdata,
    decode_if.regfile                     rf
);
    logic [XLEN-1:0] regs [NUM_REGS];

    // r0 reads zero, a same-cycle write is visible right away
    function automatic logic [XLEN-1:0] read_port(input logic [id_pkg::reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_we && wb_waddr == addr) begin
            return wb_wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    assign rf.rdata1 = read_port(rf.raddr1);
    assign rf.rdata2 = read_port(rf.raddr2);

    // writeback side should never aim at r0
    a_no_r0_write: assert property (@(posedge clk) disable iff (!resetn)
        wb_we |-> wb_waddr != '0);

endmodule

//--- dv/id_stimulus.hex
// grp inst pc wb wdata hold | expected: alu_op src1 src2 rf taken target
// wb, rf: bit 5 write enable, bits 4:0 register; grp 6 is a wrong-path fetch
1 0010148a 1c000000 24 00000005 1 0 00000005 00000000 2a 0 00000000
1 0011148b 1c000004 25 fffffff0 0 1 00000005 fffffff0 2b 0 00000000
1 001210ac 1c000008 26 80000000 0 2 fffffff0 00000005 2c 0 00000000
1 001290cd 1c00000c 27 00000003 2 3 80000000 00000005 2d 0 00000000
1 00181ccf 1c000010 00 00000000 0 a 80000000 00000003 2f 0 00000000
2 02bfe0b0 1c000014 00 00000000 1 0 fffffff0 fffffff8 30 0 00000000
2 03a00091 1c000018 00 00000000 0 5 00000005 00000800 31 0 00000000
2 0048fcd2 1c00001c 00 00000000 0 a 80000000 0000001f 32 0 00000000
2 14246813 1c000020 00 00000000 0 b 00000000 12340000 33 0 00000000
2 1c000034 1c000024 00 00000000 0 0 1c000024 00001000 34 0 00000000
3 58004084 1c000028 00 00000000 1 c 00000005 00000005 04 1 1c000068
6 03a00091 1c00002c 00 00000000 0 0 00000000 00000000 00 0 00000000
3 680080a4 1c000068 00 00000000 0 c fffffff0 00000005 04 0 00000000
3 640020c4 1c00006c 00 00000000 0 c 80000000 00000005 04 0 00000000
3 54040000 1c000070 00 00000000 0 0 1c000070 00000004 21 1 1c000470
6 0011148b 1c000074 00 00000000 0 0 00000000 00000000 00 0 00000000
4 00100117 1c000470 28 0badcafe 0 0 0badcafe 00000000 37 0 00000000
4 00159118 1c000474 24 11111111 0 7 0badcafe 11111111 38 0 00000000
5 00171d19 1c000478 00 00000000 6 8 0badcafe 00000003 39 0 00000000
3 4c002096 1c00047c 00 00000000 3 0 1c00047c 00000004 36 1 11111131
6 00181ccf 1c000480 00 00000000 0 0 00000000 00000000 00 0 00000000
5 037fc11a 11111130 00 00000000 4 4 0badcafe 00000ff0 3a 0 00000000

//--- dv/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int num_recs  = 22;
    localparam int rec_words = 12;
    // record columns
    localparam int c_grp    = 0;
    localparam int c_inst   = 1;
    localparam int c_pc     = 2;
    localparam int c_wb     = 3;
    localparam int c_wdata  = 4;
    localparam int c_hold   = 5;
    localparam int c_op     = 6;
    localparam int c_src1   = 7;
    localparam int c_src2   = 8;
    localparam int c_rf     = 9;
    localparam int c_taken  = 10;
    localparam int c_target = 11;

    logic        clk;
    logic        resetn;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        id_allowin;
    logic        ex_allowin;
    logic        out_valid;
    logic [3:0]  alu_op;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] rkd_value;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] pc;
    logic        br_taken;
    logic [31:0] br_target;
    logic        wb_we;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;

    logic [31:0] stim [num_recs*rec_words];
    logic [31:0] shadow_regs [32] = '{default: 32'h0};  // register values seen by writeback
    logic [31:0] rng_state = 32'hb3fb0192;
    int cycles = 0;
    int limit  = 1000000;  // replaced once the vectors are loaded
    int cur_test = 0;
    int test_errors = 0;
    int passed = 0;
    int failed = 0;

    id_stage #(.XLEN(xlen), .NUM_REGS(num_regs)) u_id_stage (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .id_allowin (id_allowin),
        .ex_allowin (ex_allowin),
        .out_valid  (out_valid),
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .rkd_value  (rkd_value),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .pc         (pc),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int r, input int c);
        return stim[r*rec_words + c];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // second source register value: rd for conditional branches, rk otherwise
    function automatic logic [31:0] expected_rkd(input logic [31:0] inst);
        logic [4:0] addr;
        if (inst[31:26] >= 6'h16 && inst[31:26] <= 6'h1b) begin
            addr = inst[4:0];
        end else begin
            addr = inst[14:10];
        end
        return (addr == 5'd0) ? 32'h0 : shadow_regs[addr];
    endfunction

    function automatic string test_name(input int r);
        string grp;
        case (field(r, c_grp))
            1: grp = "reg_reg";
            2: grp = "immediate";
            3: grp = "branch";
            4: grp = "bypass";
            5: grp = "backpressure";
            6: grp = "squash";
            default: grp = "unknown";
        endcase
        return $sformatf("%s_%0d", grp, r);
    endfunction

    task automatic offer(input int r);
        in_valid = (r < num_recs);  // fetch runs dry after the last record
        if (r < num_recs) begin
            in_inst = field(r, c_inst);
            in_pc   = field(r, c_pc);
        end
    endtask

    task automatic drive_wb(input int r);
        logic [31:0] wb;
        wb       = (r < 0) ? 32'h0 : field(r, c_wb);  // r < 0 idles the port
        wb_we    = wb[5];
        wb_waddr = wb[4:0];
        wb_wdata = (r < 0) ? 32'h0 : field(r, c_wdata);
        if (wb_we && wb_waddr != 5'd0) begin
            shadow_regs[wb_waddr] = wb_wdata;  // bypass shows it in the same cycle
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int r, input logic exp_allowin);
        check_word("out_valid", 32'd1, {31'b0, out_valid});
        check_word("id_allowin", {31'b0, exp_allowin}, {31'b0, id_allowin});
        check_word("pc", field(r, c_pc), pc);
        check_word("alu_op", field(r, c_op), {28'b0, alu_op});
        check_word("alu_src1", field(r, c_src1), alu_src1);
        check_word("alu_src2", field(r, c_src2), alu_src2);
        check_word("rkd_value", expected_rkd(field(r, c_inst)), rkd_value);
        check_word("rf_we/rf_waddr", field(r, c_rf), {26'b0, rf_we, rf_waddr});
        check_word("br_taken", field(r, c_taken), {31'b0, br_taken});
        if (field(r, c_taken) != 0) begin
            check_word("br_target", field(r, c_target), br_target);  // don't care otherwise
        end
    endtask

    task automatic finish_test(input int r);
        if (test_errors == 0) begin
            passed++;
            $display("test %s: pass", test_name(r));
        end else begin
            failed++;
            $display("test %s: fail with %0d mismatches", test_name(r), test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int cur;
        int nxt;
        int stall;
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_inst    = '0;
        in_pc      = '0;
        ex_allowin = 1'b0;
        drive_wb(-1);
        $readmemh("dv/id_stimulus.hex", stim);
        limit = 50;
        for (int r = 0; r < num_recs; r++) begin
            limit += int'(field(r, c_hold)) + 5;
        end
        repeat (8) @(negedge clk);
        resetn     = 1'b1;
        ex_allowin = 1'b1;
        offer(0);
        #10;
        while (!id_allowin) begin  // first instruction needs an empty stage
            @(negedge clk);
            #10;
        end
        @(posedge clk);
        cur = 0;
        while (cur < num_recs) begin
            cur_test  = cur;
            nxt       = cur + 1;
            rng_state = xorshift32(rng_state);
            stall     = int'(field(cur, c_hold)) + int'(rng_state[1:0]);
            repeat (stall) begin
                @(negedge clk);
                ex_allowin = 1'b0;  // execute busy, next one must wait
                drive_wb(cur);
                offer(nxt);
                #10;
                check_outputs(cur, 1'b0);
            end
            @(negedge clk);
            ex_allowin = 1'b1;
            drive_wb(cur);
            offer(nxt);
            #10;
            check_outputs(cur, 1'b1);
            @(posedge clk);  // transfer, nxt enters unless squashed
            finish_test(cur);
            if (field(cur, c_taken) != 0 && nxt < num_recs) begin
                // nxt came down the wrong path, stage should now be empty
                cur_test = nxt;
                @(negedge clk);
                drive_wb(-1);
                offer(nxt + 1);
                #10;
                check_word("out_valid", 32'd0, {31'b0, out_valid});
                @(posedge clk);
                finish_test(nxt);
                nxt = nxt + 1;
            end
            cur = nxt;
        end
        drive_wb(-1);
        in_valid = 1'b0;
        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
